//--- verilog.f
+incdir+logic
logic/apu_cluster_pkg.sv
logic/apu_arbiter.sv
logic/int_mult_unit.sv
logic/int_div_unit.sv
logic/apu_result_return.sv
logic/apu_cluster.sv
bench/apu_cluster_chk.sv
bench/apu_cluster_tb.sv

//--- Bender.yml
package:
  name: apu_cluster

export_include_dirs:
  - logic

sources:
  - logic/apu_cluster_pkg.sv
  - logic/apu_arbiter.sv
  - logic/int_mult_unit.sv
  - logic/int_div_unit.sv
  - logic/apu_result_return.sv
  - logic/apu_cluster.sv
  - target: simulation
    files:
      - bench/apu_cluster_chk.sv
      - bench/apu_cluster_tb.sv

//--- bench/apu_cluster_tb.sv
// Testbench for the shared multiplier and divider cluster
// Each core walks its own table entries with one operation outstanding
// Expected values come from a behavioral model of the seven operations

`timescale 1ns/1ns
`default_nettype none

`include "apu_cluster_defs.svh"

module apu_cluster_tb;

   localparam int NB       = `APU_NB_CORES;
   localparam int DW       = `APU_DATA_W;
   localparam int PERIOD   = 40;
   localparam int MAX_TEST = 64;

   logic                               clk_i;
   logic                               arst_n_i;
   logic [NB-1:0]                      req_i;
   apu_cluster_pkg::apu_req_t [NB-1:0] req_data_i;
   logic [NB-1:0]                      ack_o;
   logic [NB-1:0]                      rsp_valid_o;
   logic [NB-1:0][DW-1:0]              rsp_data_o;

   // Stimulus table
   string                     t_name [MAX_TEST];
   int                        t_core [MAX_TEST];
   apu_cluster_pkg::apu_req_t t_req  [MAX_TEST];
   logic [DW-1:0]             t_exp  [MAX_TEST];
   int                        n_tests;
   int                        n_pass;
   int                        n_fail;
   logic                      table_ready;
   integer                    seed;

   apu_cluster i_dut (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .req_i       (req_i),
      .req_data_i  (req_data_i),
      .ack_o       (ack_o),
      .rsp_valid_o (rsp_valid_o),
      .rsp_data_o  (rsp_data_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #(PERIOD / 2) clk_i = ~clk_i;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Operation encoding and reference model

   function automatic apu_cluster_pkg::apu_req_t encode_op(string mnem, logic [DW-1:0] a,
                                                          logic [DW-1:0] b);
      apu_cluster_pkg::apu_req_t r;
      r.a        = a;
      r.b        = b;
      r.op       = '0;
      r.apu_type = (mnem[0] == "M") ? apu_cluster_pkg::APU_MULT : apu_cluster_pkg::APU_DIV;
      case (mnem)
         "MUL":   r.op.mult_op = '{high: 1'b0, signed_ops: 1'b1};
         "MULH":  r.op.mult_op = '{high: 1'b1, signed_ops: 1'b1};
         "MULHU": r.op.mult_op = '{high: 1'b1, signed_ops: 1'b0};
         "DIV":   r.op.div_op  = '{rem: 1'b0, unsigned_ops: 1'b0};
         "DIVU":  r.op.div_op  = '{rem: 1'b0, unsigned_ops: 1'b1};
         "REM":   r.op.div_op  = '{rem: 1'b1, unsigned_ops: 1'b0};
         "REMU":  r.op.div_op  = '{rem: 1'b1, unsigned_ops: 1'b1};
         default: r.op = '0;
      endcase
      return r;
   endfunction

   function automatic logic [DW-1:0] ref_model(apu_cluster_pkg::apu_req_t r);
      logic [2*DW-1:0] xa;
      logic [2*DW-1:0] xb;
      logic [2*DW-1:0] prod;
      logic [DW-1:0]   quo;
      logic [DW-1:0]   rem;
      if (r.apu_type == apu_cluster_pkg::APU_MULT) begin
         // Full product modulo 2^64 of the extended operands
         xa   = r.op.mult_op.signed_ops ? {{DW{r.a[DW-1]}}, r.a} : {{DW{1'b0}}, r.a};
         xb   = r.op.mult_op.signed_ops ? {{DW{r.b[DW-1]}}, r.b} : {{DW{1'b0}}, r.b};
         prod = xa * xb;
         return r.op.mult_op.high ? prod[2*DW-1:DW] : prod[DW-1:0];
      end
      if (r.b == '0) begin
         quo = '1;
         rem = r.a;
      end else if (r.op.div_op.unsigned_ops) begin
         quo = r.a / r.b;
         rem = r.a % r.b;
      end else if (r.a == {1'b1, {(DW-1){1'b0}}} && r.b == '1) begin
         quo = r.a;
         rem = '0;
      end else begin
         // Truncating division, remainder follows the dividend
         quo = $signed(r.a) / $signed(r.b);
         rem = $signed(r.a) % $signed(r.b);
      end
      return r.op.div_op.rem ? rem : quo;
   endfunction

   function automatic void add_test(int core, string mnem, logic [DW-1:0] a,
                                    logic [DW-1:0] b);
      t_core[n_tests] = core;
      t_req[n_tests]  = encode_op(mnem, a, b);
      t_exp[n_tests]  = ref_model(t_req[n_tests]);
      t_name[n_tests] = $sformatf("c%0d_%s_%0d", core, mnem, n_tests);
      n_tests++;
   endfunction

   function automatic void build_table();
      string         mnem [7] = '{"MUL", "MULH", "MULHU", "DIV", "DIVU", "REM", "REMU"};
      logic [DW-1:0] a;
      logic [DW-1:0] b;
      // First entry of every core is a divide, three wait on the busy divider
      add_test(0, "DIV",   32'hffff_fff9, 32'd2);
      add_test(1, "REM",   32'hffff_fff9, 32'd2);
      add_test(2, "DIVU",  32'hffff_fff9, 32'd2);
      add_test(3, "REM",   32'd7,         32'hffff_fffe);
      add_test(0, "MUL",   32'hffff_fffd, 32'd5);
      add_test(0, "MULH",  32'hffff_fffd, 32'd5);
      add_test(0, "MULHU", 32'hffff_fffd, 32'd5);
      add_test(0, "MULH",  32'h8000_0000, 32'h8000_0000);
      // Divide by zero and overflow
      add_test(1, "DIV",   32'h1234_5678, 32'd0);
      add_test(1, "REM",   32'h8765_4321, 32'd0);
      add_test(1, "DIVU",  32'h8765_4321, 32'd0);
      add_test(1, "DIV",   32'h8000_0000, 32'hffff_ffff);
      add_test(1, "REM",   32'h8000_0000, 32'hffff_ffff);
      add_test(2, "REMU",  32'hffff_fff9, 32'd10);
      add_test(2, "DIV",   32'h7fff_ffff, 32'hffff_fffd);
      add_test(3, "REMU",  32'h0000_0064, 32'd7);
      // Rotating mnemonics mix multiplies and divides across the cores
      for (int i = 0; i < 6; i++) begin
         for (int c = 0; c < NB; c++) begin
            a = $random(seed);
            b = $random(seed);
            add_test(c, mnem[(i + c) % 7], a, b);
         end
      end
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Core driver, four-phase req/ack then wait for the result

   task automatic run_core(int core);
      logic [DW-1:0] actual;
      bit            got;
      bit            acked;
      for (int i = 0; i < n_tests; i++) begin
         if (t_core[i] != core) begin
            continue;
         end
         got   = 1'b0;
         acked = 1'b0;
         @(posedge clk_i);
         req_i[core]      <= 1'b1;
         req_data_i[core] <= t_req[i];
         while (!got) begin
            @(negedge clk_i);
            if (rsp_valid_o[core]) begin
               got    = 1'b1;
               actual = rsp_data_o[core];
            end
            if (ack_o[core] && !acked) begin
               acked = 1'b1;
               @(posedge clk_i);
               req_i[core] <= 1'b0;
            end
         end
         while (ack_o[core]) begin
            @(negedge clk_i);
         end
         assert (actual === t_exp[i]) begin
            n_pass++;
            $display("ok  %s %h", t_name[i], actual);
         end else begin
            n_fail++;
            $display("ERR %s expected %h actual %h", t_name[i], t_exp[i], actual);
         end
      end
   endtask

   initial begin
      seed        = 32'h512b;
      n_tests     = 0;
      n_pass      = 0;
      n_fail      = 0;
      arst_n_i    = 1'b0;
      req_i       = '0;
      req_data_i  = '0;
      table_ready = 1'b0;
      build_table();
      table_ready = 1'b1;
      repeat (10) @(posedge clk_i);
      arst_n_i <= 1'b1;
      fork
         run_core(0);
         run_core(1);
         run_core(2);
         run_core(3);
      join
      repeat (4) @(posedge clk_i);
      $display("Tests %0d, passed %0d, failed %0d, assertion failures %0d",
               n_tests, n_pass, n_fail, i_dut.i_chk.err_cnt);
      if (n_fail == 0 && n_pass == n_tests && i_dut.i_chk.err_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // Watchdog sized from the table length
   initial begin
      wait (table_ready);
      repeat (10 + n_tests * (`APU_DIV_STEPS + 10) * 4) @(posedge clk_i);
      $display("Watchdog expired before every core received its results");
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- bench/apu_cluster_chk.sv
// Port protocol checks, bound into apu_cluster
// Assumes cores hold req until ack and keep one operation outstanding

`timescale 1ns/1ns
`default_nettype none

`include "apu_cluster_defs.svh"

module apu_cluster_chk (
   input logic                     clk_i,
   input logic                     arst_n_i,
   input logic [`APU_NB_CORES-1:0] req_i,
   input logic [`APU_NB_CORES-1:0] ack_i,
   input logic [`APU_NB_CORES-1:0] rsp_valid_i
);

   logic [`APU_NB_CORES-1:0] acked_q;
   int unsigned              err_cnt = 0;

   // Cores that have had at least one request acked
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         acked_q <= '0;
      end else begin
         acked_q <= acked_q | ack_i;
      end
   end

   for (genvar c = 0; c < `APU_NB_CORES; c++) begin : g_core
      ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         $rose(ack_i[c]) |-> req_i[c])
      else begin
         $error("ack rose without req on core %0d", c);
         err_cnt++;
      end
      rsp_single_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         rsp_valid_i[c] |=> !rsp_valid_i[c])
      else begin
         $error("result valid held longer than one cycle on core %0d", c);
         err_cnt++;
      end
      rsp_after_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         !acked_q[c] |-> !rsp_valid_i[c])
      else begin
         $error("result shown to core %0d before any ack", c);
         err_cnt++;
      end
      ack_drops: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         $fell(req_i[c]) |-> ##[0:2] !ack_i[c])
      else begin
         $error("ack stayed high after req fell on core %0d", c);
         err_cnt++;
      end
   end

endmodule

bind apu_cluster apu_cluster_chk i_chk (
   .clk_i       (clk_i),
   .arst_n_i    (arst_n_i),
   .req_i       (req_i),
   .ack_i       (ack_o),
   .rsp_valid_i (rsp_valid_o)
);

`default_nettype wire

//--- logic/apu_cluster.sv
// Shared multiplier and divider for all cores of the cluster
// A core has one operation outstanding and takes its result when shown

`timescale 1ns/1ns
`default_nettype none

`include "apu_cluster_defs.svh"

module apu_cluster (
   input  logic                                          clk_i,
   input  logic                                          arst_n_i,
   input  logic [`APU_NB_CORES-1:0]                      req_i,
   input  apu_cluster_pkg::apu_req_t [`APU_NB_CORES-1:0] req_data_i,
   output logic [`APU_NB_CORES-1:0]                      ack_o,
   output logic [`APU_NB_CORES-1:0]                      rsp_valid_o,
   output logic [`APU_NB_CORES-1:0][`APU_DATA_W-1:0]     rsp_data_o
);

   logic [`APU_NB_CORES-1:0]     mult_ack;
   logic [`APU_NB_CORES-1:0]     div_ack;
   logic                         mult_issue_valid;
   logic                         div_issue_valid;
   logic                         div_ready;
   apu_cluster_pkg::apu_issue_t  mult_issue;
   apu_cluster_pkg::apu_issue_t  div_issue;
   apu_cluster_pkg::apu_result_t mult_result;
   apu_cluster_pkg::apu_result_t div_result;

   ////////////////////////////////////////////////////////////////////////////
   // Arbiters, one per unit type

   apu_arbiter #(
      .UNIT_TYPE (apu_cluster_pkg::APU_MULT)
   ) i_mult_arb (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .req_i         (req_i),
      .req_data_i    (req_data_i),
      .unit_ready_i  (1'b1),
      .ack_o         (mult_ack),
      .issue_valid_o (mult_issue_valid),
      .issue_o       (mult_issue)
   );

   apu_arbiter #(
      .UNIT_TYPE (apu_cluster_pkg::APU_DIV)
   ) i_div_arb (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .req_i         (req_i),
      .req_data_i    (req_data_i),
      .unit_ready_i  (div_ready),
      .ack_o         (div_ack),
      .issue_valid_o (div_issue_valid),
      .issue_o       (div_issue)
   );

   // Each request names one type, so at most one arbiter acks a core
   assign ack_o = mult_ack | div_ack;

   ////////////////////////////////////////////////////////////////////////////
   // Execution units and result return

   int_mult_unit i_mult (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .issue_valid_i (mult_issue_valid),
      .issue_i       (mult_issue),
      .result_o      (mult_result)
   );

   int_div_unit i_div (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .issue_valid_i (div_issue_valid),
      .issue_i       (div_issue),
      .ready_o       (div_ready),
      .result_o      (div_result)
   );

   apu_result_return i_ret (
      .mult_result_i (mult_result),
      .div_result_i  (div_result),
      .rsp_valid_o   (rsp_valid_o),
      .rsp_data_o    (rsp_data_o)
   );

endmodule

`default_nettype wire

//--- logic/apu_result_return.sv
// Steers unit results back to the core named by the tag
// Two results never target the same core in one cycle

`timescale 1ns/1ns
`default_nettype none

`include "apu_cluster_defs.svh"

module apu_result_return (
   input  apu_cluster_pkg::apu_result_t             mult_result_i,
   input  apu_cluster_pkg::apu_result_t             div_result_i,
   output logic [`APU_NB_CORES-1:0]                 rsp_valid_o,
   output logic [`APU_NB_CORES-1:0][`APU_DATA_W-1:0] rsp_data_o
);

   localparam int NB    = `APU_NB_CORES;
   localparam int TAG_W = `APU_TAG_W;

   always_comb begin
      rsp_valid_o = '0;
      rsp_data_o  = '0;
      for (int c = 0; c < NB; c++) begin
         if (mult_result_i.valid && (mult_result_i.tag == TAG_W'(c))) begin
            rsp_valid_o[c] = 1'b1;
            rsp_data_o[c]  = mult_result_i.result;
         end
         // Divider result for a different core may land in the same cycle
         if (div_result_i.valid && (div_result_i.tag == TAG_W'(c))) begin
            rsp_valid_o[c] = 1'b1;
            rsp_data_o[c]  = div_result_i.result;
         end
      end
   end

endmodule

`default_nettype wire

//--- logic/int_div_unit.sv
// Radix-2 restoring divider, one item at a time
// Fixed latency of APU_DIV_STEPS plus 2 cycles, divide by zero included
// ready_o is high only while idle

`timescale 1ns/1ns
`default_nettype none

`include "apu_cluster_defs.svh"

module int_div_unit (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  logic                         issue_valid_i,
   input  apu_cluster_pkg::apu_issue_t  issue_i,
   output logic                         ready_o,
   output apu_cluster_pkg::apu_result_t result_o
);

   localparam int DW    = `APU_DATA_W;
   localparam int STEPS = `APU_DIV_STEPS;
   localparam int CNT_W = $clog2(STEPS);

   localparam logic [1:0] S_IDLE = 2'd0;
   localparam logic [1:0] S_RUN  = 2'd1;
   localparam logic [1:0] S_FIX  = 2'd2;

   logic [1:0]            state_q;
   logic [CNT_W-1:0]      cnt_q;
   logic                  res_valid_q;
   logic [DW-1:0]         res_data_q;
   logic [DW-1:0]         divisor_q;
   logic [DW-1:0]         quo_q;
   logic [DW-1:0]         rem_q;
   logic [`APU_TAG_W-1:0] tag_q;
   logic                  rem_sel_q;
   logic                  quo_neg_q;
   logic                  rem_neg_q;
   logic                  signed_op;
   logic [DW-1:0]         abs_a;
   logic [DW-1:0]         abs_b;
   logic [DW:0]           shifted;
   logic [DW:0]           diff;

   assign signed_op = !issue_i.op.div_op.unsigned_ops;
   assign abs_a     = (signed_op && issue_i.a[DW-1]) ? -issue_i.a : issue_i.a;
   assign abs_b     = (signed_op && issue_i.b[DW-1]) ? -issue_i.b : issue_i.b;

   // Partial remainder stays below the divisor, so a borrow means no fit
   assign shifted = {rem_q, quo_q[DW-1]};
   assign diff    = shifted - {1'b0, divisor_q};

   ////////////////////////////////////////////////////////////////////////////
   // Control FSM

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q     <= S_IDLE;
         cnt_q       <= '0;
         res_valid_q <= 1'b0;
      end else begin
         res_valid_q <= 1'b0;
         case (state_q)
            S_IDLE: begin
               cnt_q <= '0;
               if (issue_valid_i) begin
                  state_q <= S_RUN;
               end
            end
            S_RUN: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == CNT_W'(STEPS - 1)) begin
                  state_q <= S_FIX;
               end
            end
            S_FIX: begin
               state_q     <= S_IDLE;
               res_valid_q <= 1'b1;
            end
            default: state_q <= S_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Datapath

   always_ff @(posedge clk_i) begin
      if (state_q == S_IDLE && issue_valid_i) begin
         quo_q     <= abs_a;
         rem_q     <= '0;
         divisor_q <= abs_b;
         tag_q     <= issue_i.tag;
         rem_sel_q <= issue_i.op.div_op.rem;
         // Zero divisor keeps the all-ones quotient unsigned
         quo_neg_q <= signed_op && (issue_i.a[DW-1] ^ issue_i.b[DW-1]) && (issue_i.b != '0);
         rem_neg_q <= signed_op && issue_i.a[DW-1];
      end else if (state_q == S_RUN) begin
         quo_q <= {quo_q[DW-2:0], !diff[DW]};
         rem_q <= diff[DW] ? shifted[DW-1:0] : diff[DW-1:0];
      end else if (state_q == S_FIX) begin
         if (rem_sel_q) begin
            res_data_q <= rem_neg_q ? -rem_q : rem_q;
         end else begin
            res_data_q <= quo_neg_q ? -quo_q : quo_q;
         end
      end
   end

   assign ready_o         = (state_q == S_IDLE);
   assign result_o.valid  = res_valid_q;
   assign result_o.tag    = tag_q;
   assign result_o.result = res_data_q;

endmodule

`default_nettype wire

//--- logic/int_mult_unit.sv
// Three-stage integer multiplier, one new item per cycle
// Result appears exactly three cycles after the issue cycle

`timescale 1ns/1ns
`default_nettype none

`include "apu_cluster_defs.svh"

module int_mult_unit (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  logic                         issue_valid_i,
   input  apu_cluster_pkg::apu_issue_t  issue_i,
   output apu_cluster_pkg::apu_result_t result_o
);

   localparam int DW = `APU_DATA_W;

   logic                  s1_valid_q;
   logic                  s2_valid_q;
   logic                  s3_valid_q;
   logic [`APU_TAG_W-1:0] s1_tag_q;
   logic [`APU_TAG_W-1:0] s2_tag_q;
   logic [`APU_TAG_W-1:0] s3_tag_q;
   logic                  s1_high_q;
   logic                  s2_high_q;
   logic signed [DW:0]    s1_a_q;
   logic signed [DW:0]    s1_b_q;
   logic [2*DW-1:0]       s2_prod_q;
   logic [DW-1:0]         s3_res_q;

   // Valid bits walk with the data
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         s1_valid_q <= 1'b0;
         s2_valid_q <= 1'b0;
         s3_valid_q <= 1'b0;
      end else begin
         s1_valid_q <= issue_valid_i;
         s2_valid_q <= s1_valid_q;
         s3_valid_q <= s2_valid_q;
      end
   end

   always_ff @(posedge clk_i) begin
      // Stage 1, one extra bit turns unsigned operands into positive ones
      s1_a_q    <= {issue_i.op.mult_op.signed_ops & issue_i.a[DW-1], issue_i.a};
      s1_b_q    <= {issue_i.op.mult_op.signed_ops & issue_i.b[DW-1], issue_i.b};
      s1_high_q <= issue_i.op.mult_op.high;
      s1_tag_q  <= issue_i.tag;
      // Stage 2, low 2*DW bits of the signed product
      s2_prod_q <= s1_a_q * s1_b_q;
      s2_high_q <= s1_high_q;
      s2_tag_q  <= s1_tag_q;
      // Stage 3, word select
      s3_res_q  <= s2_high_q ? s2_prod_q[2*DW-1:DW] : s2_prod_q[DW-1:0];
      s3_tag_q  <= s2_tag_q;
   end

   assign result_o.valid  = s3_valid_q;
   assign result_o.tag    = s3_tag_q;
   assign result_o.result = s3_res_q;

endmodule

`default_nettype wire

//--- logic/apu_arbiter.sv
// Round-robin arbiter between all cores for one unit type
// Cores keep req and its data stable until ack rises
// Issue is combinational, the unit captures on the edge that raises ack

`timescale 1ns/1ns
`default_nettype none

`include "apu_cluster_defs.svh"

module apu_arbiter #(
   parameter apu_cluster_pkg::apu_type_e UNIT_TYPE = apu_cluster_pkg::APU_MULT
) (
   input  logic                                          clk_i,
   input  logic                                          arst_n_i,
   input  logic [`APU_NB_CORES-1:0]                      req_i,
   input  apu_cluster_pkg::apu_req_t [`APU_NB_CORES-1:0] req_data_i,
   input  logic                                          unit_ready_i,
   output logic [`APU_NB_CORES-1:0]                      ack_o,
   output logic                                          issue_valid_o,
   output apu_cluster_pkg::apu_issue_t                   issue_o
);

   localparam int NB    = `APU_NB_CORES;
   localparam int TAG_W = `APU_TAG_W;

   logic [NB-1:0]    ack_q;
   logic [NB-1:0]    eligible;
   logic [TAG_W-1:0] rr_q;
   logic [TAG_W-1:0] scan_idx;
   logic [TAG_W-1:0] grant_idx;
   logic             grant_found;

   // Only fresh requests of this unit type compete
   always_comb begin
      for (int c = 0; c < NB; c++) begin
         eligible[c] = req_i[c] && !ack_q[c] &&
                       (req_data_i[c].apu_type == UNIT_TYPE);
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Round-robin search, starting after the last winner

   always_comb begin
      grant_found = 1'b0;
      grant_idx   = '0;
      scan_idx    = rr_q;
      for (int k = 1; k <= NB; k++) begin
         scan_idx = rr_q + TAG_W'(k);
         if (!grant_found && eligible[scan_idx]) begin
            grant_found = 1'b1;
            grant_idx   = scan_idx;
         end
      end
   end

   assign issue_valid_o = grant_found && unit_ready_i;

   always_comb begin
      issue_o.op  = req_data_i[grant_idx].op;
      issue_o.a   = req_data_i[grant_idx].a;
      issue_o.b   = req_data_i[grant_idx].b;
      issue_o.tag = grant_idx;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Four-phase ack state

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_q <= '0;
         rr_q  <= '1;
      end else begin
         for (int c = 0; c < NB; c++) begin
            if (!req_i[c]) begin
               ack_q[c] <= 1'b0;
            end
         end
         if (issue_valid_o) begin
            ack_q[grant_idx] <= 1'b1;
            rr_q             <= grant_idx;
         end
      end
   end

   assign ack_o = ack_q;

endmodule

`default_nettype wire

//--- logic/apu_cluster_pkg.sv
// Types exchanged between cores, arbiters and execution units
// Operand widths come from the shared defines header

`default_nettype none

`include "apu_cluster_defs.svh"

package apu_cluster_pkg;

   // Which unit an operation is meant for
   typedef enum logic {
      APU_MULT = 1'b0,
      APU_DIV  = 1'b1
   } apu_type_e;

   // MUL is low word, MULH high signed, MULHU high unsigned
   typedef struct packed {
      logic high;
      logic signed_ops;
   } mult_op_t;

   // DIV, DIVU, REM, REMU
   typedef struct packed {
      logic rem;
      logic unsigned_ops;
   } div_op_t;

   // Same two bits, read by whichever unit receives them
   typedef union packed {
      mult_op_t mult_op;
      div_op_t  div_op;
   } apu_op_u;

   typedef struct packed {
      apu_type_e               apu_type;
      apu_op_u                 op;
      logic [`APU_DATA_W-1:0]  a;
      logic [`APU_DATA_W-1:0]  b;
   } apu_req_t;

   typedef struct packed {
      apu_op_u                 op;
      logic [`APU_DATA_W-1:0]  a;
      logic [`APU_DATA_W-1:0]  b;
      logic [`APU_TAG_W-1:0]   tag;
   } apu_issue_t;

   typedef struct packed {
      logic                    valid;
      logic [`APU_TAG_W-1:0]   tag;
      logic [`APU_DATA_W-1:0]  result;
   } apu_result_t;

endpackage

`default_nettype wire

//--- logic/apu_cluster_defs.svh
// Sizes shared by the whole execution cluster
// The core count must be a power of two and APU_TAG_W its log2
// APU_DIV_STEPS must equal APU_DATA_W, one quotient bit per step

`ifndef APU_CLUSTER_DEFS_SVH
`define APU_CLUSTER_DEFS_SVH

// Cores sharing the units
`define APU_NB_CORES 4

// Core index carried with every operation
`define APU_TAG_W 2

// Operand and result width
`define APU_DATA_W 32

// Iterations of the restoring divider
`define APU_DIV_STEPS 32

`endif
